//--- Bender.yml
package:
  name: la_top

sources:
  - la_pkg.sv
  - la_icb_regs.sv
  - la_trigger.sv
  - la_capture.sv
  - la_sample_mem.sv
  - la_top.sv
  - target: test
    files:
      - la_asserts.sv
      - tb_la_top.sv

//--- la_asserts.sv
/* bus and arbiter rules for la_top, bound into every la_top instance */
`default_nettype none

module la_asserts (
  input logic              sys_clk,
  input logic              sys_rst_n,
  input logic              i_cmd_valid,
  input logic              i_cmd_ready,
  input logic              i_rsp_valid,
  input logic              i_rsp_ready,
  input logic [31:0]       i_rsp_rdata,
  input logic              i_rd_req,
  input logic              i_rd_gnt,
  input logic              i_wr_en
);
  timeunit 1ns;
  timeprecision 1ps;

  int   fail_cnt = 0;
  logic pending;

  // one command in flight, from its transfer until its response transfers
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_n)
      pending <= 1'b0;
    else if (i_cmd_valid && i_cmd_ready)
      pending <= 1'b1;
    else if (i_rsp_valid && i_rsp_ready)
      pending <= 1'b0;
  end

  // a response waits with its data until it is taken
  a_rsp_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    i_rsp_valid && !i_rsp_ready |=> i_rsp_valid && $stable(i_rsp_rdata))
    else begin
      $error("response dropped or changed before rsp_ready");
      fail_cnt++;
    end

  a_one_cmd: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    pending |-> !i_cmd_ready)
    else begin
      $error("command accepted while a response is pending");
      fail_cnt++;
    end

  // no response without an accepted command
  a_rsp_owed: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    i_rsp_valid |-> pending)
    else begin
      $error("response given with no command outstanding");
      fail_cnt++;
    end

  // a waiting read gets the port on the first cycle the writer leaves free
  a_gnt_excl: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    i_rd_req |-> (i_rd_gnt != i_wr_en))
    else begin
      $error("read grant together with a capture write, or free port not granted");
      fail_cnt++;
    end

endmodule

bind la_top la_asserts u_asserts (
  .sys_clk     (sys_clk),
  .sys_rst_n   (sys_rst_n),
  .i_cmd_valid (i_icb_cmd_valid),
  .i_cmd_ready (o_icb_cmd_ready),
  .i_rsp_valid (o_icb_rsp_valid),
  .i_rsp_ready (i_icb_rsp_ready),
  .i_rsp_rdata (o_icb_rsp_rdata),
  .i_rd_req    (rd_req),
  .i_rd_gnt    (rd_gnt),
  .i_wr_en     (wr_en)
);

`default_nettype wire

//--- la_capture.sv
/* circular capture from address 0; the trigger is accepted only after pre_num
   samples, then MEM_DEPTH - pre_num - 1 more samples end the window */
`default_nettype none

module la_capture import la_pkg::*; #(
  parameter  int MEM_DEPTH = 256,
  localparam int MEM_AW    = $clog2(MEM_DEPTH)
) (
  input  logic               sys_clk,
  input  logic               sys_rst_n,
  input  logic               i_arm,
  input  logic [MEM_AW-1:0]  i_pre_num,
  input  logic               i_smp_stb,
  input  logic [PROBE_W-1:0] i_smp_data,
  input  logic               i_hit_raw,
  output logic               o_wr_en,
  output logic [MEM_AW-1:0]  o_wr_addr,
  output logic [PROBE_W-1:0] o_wr_data,
  output logic               o_finished,
  output logic [MEM_AW-1:0]  o_trig_addr
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_PRE  = 2'd1;
  localparam logic [1:0] ST_POST = 2'd2;

  logic [1:0]        state;
  logic [MEM_AW-1:0] pre_cnt;
  logic [MEM_AW-1:0] post_left;
  logic [MEM_AW-1:0] post_num;
  logic              pre_done;
  logic              is_trig;

  // MEM_DEPTH - 1 - pre_num in MEM_AW bits
  assign post_num = ~i_pre_num;
  assign pre_done = (pre_cnt == i_pre_num);

  assign o_wr_en   = i_arm & i_smp_stb;
  assign o_wr_data = i_smp_data;

  // first write of the arming cycle still finds the FSM idle
  assign is_trig = o_wr_en & (state != ST_POST) & pre_done & i_hit_raw;

  assign o_finished = (is_trig & (post_num == '0)) |
                      (o_wr_en & (state == ST_POST) & (post_left == MEM_AW'(1)));

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      state       <= ST_IDLE;
      o_wr_addr   <= '0;
      pre_cnt     <= '0;
      post_left   <= '0;
      o_trig_addr <= '0;
    end else if (!i_arm || o_finished) begin
      state     <= ST_IDLE;
      o_wr_addr <= '0;
      pre_cnt   <= '0;
    end else begin
      if (state == ST_IDLE)
        state <= ST_PRE;
      if (o_wr_en) begin
        o_wr_addr <= o_wr_addr + 1'b1;
        if (is_trig) begin
          state       <= ST_POST;
          post_left   <= post_num;
          o_trig_addr <= o_wr_addr;
        end else if (state == ST_POST) begin
          post_left <= post_left - 1'b1;
        end else if (!pre_done) begin
          pre_cnt <= pre_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- la_icb_regs.sv
/* ICB slave for the analyzer registers and sample window; one command outstanding,
   no byte masks, never signals an error, MEM_DEPTH up to 1024 */
`default_nettype none

module la_icb_regs import la_pkg::*; #(
  parameter  int MEM_DEPTH = 256,
  localparam int MEM_AW    = $clog2(MEM_DEPTH)
) (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic              i_cmd_valid,
  output logic              o_cmd_ready,
  input  logic [ADDR_W-1:0] i_cmd_addr,
  input  logic              i_cmd_read,
  input  logic [DATA_W-1:0] i_cmd_wdata,
  output logic              o_rsp_valid,
  input  logic              i_rsp_ready,
  output logic              o_rsp_err,
  output logic [DATA_W-1:0] o_rsp_rdata,
  input  logic              i_finished,
  input  logic [MEM_AW-1:0] i_trig_addr,
  output logic              o_arm,
  output logic [CHN_W-1:0]  o_chn_sel,
  output logic [MODE_W-1:0] o_mode_sel,
  output logic [FREQ_W-1:0] o_freq_sel,
  output logic [MEM_AW-1:0] o_pre_num,
  output logic              o_done,
  output logic              o_rd_req,
  output logic [MEM_AW-1:0] o_rd_addr,
  input  logic              i_rd_gnt,
  input  logic [PROBE_W-1:0] i_rd_data
);

  logic              rd_fetch;
  logic              cmd_hsk;
  logic              rsp_hsk;
  logic              in_win;
  logic [ADDR_W-1:0] win_off;
  logic [DATA_W-1:0] reg_rdata;

  // busy from the accepted command until its response transfers
  assign o_cmd_ready = ~(o_rsp_valid | o_rd_req | rd_fetch);
  assign cmd_hsk     = i_cmd_valid & o_cmd_ready;
  assign rsp_hsk     = o_rsp_valid & i_rsp_ready;
  assign o_rsp_err   = 1'b0;

  assign win_off = i_cmd_addr - MEM_BASE;
  assign in_win  = (i_cmd_addr >= MEM_BASE) && (win_off < ADDR_W'(MEM_DEPTH * 4));

  always_comb begin
    reg_rdata = '0;
    case (i_cmd_addr)
      REG_CTRL: reg_rdata[0]              = o_arm;
      REG_CHN:  reg_rdata[CHN_W-1:0]      = o_chn_sel;
      REG_MODE: reg_rdata[MODE_W-1:0]     = o_mode_sel;
      REG_FREQ: reg_rdata[FREQ_W-1:0]     = o_freq_sel;
      REG_PRE:  reg_rdata[MEM_AW-1:0]     = o_pre_num;
      REG_STAT: begin
        reg_rdata[STAT_DONE_BIT]            = o_done;
        reg_rdata[STAT_TA_LSB +: STAT_TA_W] = STAT_TA_W'(i_trig_addr);
      end
      default: ;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      o_arm      <= 1'b0;
      o_chn_sel  <= '0;
      o_mode_sel <= '0;
      o_freq_sel <= '0;
      o_pre_num  <= '0;
      o_done     <= 1'b0;
    end else begin
      if (cmd_hsk && !i_cmd_read) begin
        case (i_cmd_addr)
          REG_CTRL: begin
            o_arm <= i_cmd_wdata[0];
            // new capture, old result no longer valid
            if (i_cmd_wdata[0])
              o_done <= 1'b0;
          end
          REG_CHN:  o_chn_sel  <= i_cmd_wdata[CHN_W-1:0];
          REG_MODE: o_mode_sel <= i_cmd_wdata[MODE_W-1:0];
          REG_FREQ: o_freq_sel <= i_cmd_wdata[FREQ_W-1:0];
          REG_PRE:  o_pre_num  <= i_cmd_wdata[MEM_AW-1:0];
          default: ;
        endcase
      end
      // end of capture wins over a write in the same cycle
      if (i_finished) begin
        o_arm  <= 1'b0;
        o_done <= 1'b1;
      end
    end
  end

  // transaction tracking, window reads wait for the memory grant
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      o_rsp_valid <= 1'b0;
      o_rd_req    <= 1'b0;
      rd_fetch    <= 1'b0;
    end else begin
      if (rsp_hsk)
        o_rsp_valid <= 1'b0;
      if (cmd_hsk) begin
        if (i_cmd_read && in_win)
          o_rd_req <= 1'b1;
        else
          o_rsp_valid <= 1'b1;
      end
      if (o_rd_req && i_rd_gnt) begin
        o_rd_req <= 1'b0;
        rd_fetch <= 1'b1;
      end
      if (rd_fetch) begin
        rd_fetch    <= 1'b0;
        o_rsp_valid <= 1'b1;
      end
    end
  end

  // response word, held until it transfers
  always_ff @(posedge sys_clk) begin
    if (cmd_hsk) begin
      o_rd_addr   <= win_off[MEM_AW+1:2];
      o_rsp_rdata <= i_cmd_read ? reg_rdata : '0;
    end
    // memory word arrives one cycle after the grant
    if (rd_fetch)
      o_rsp_rdata <= DATA_W'(i_rd_data);
  end

endmodule

`default_nettype wire

//--- la_pkg.sv
/* constants shared by the analyzer RTL and its testbench; bus addresses are
   offsets inside the peripheral window */
`default_nettype none

package la_pkg;

  // bus and sample widths
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int PROBE_W = 8;

  // register field widths
  localparam int CHN_W  = 3;
  localparam int MODE_W = 3;
  localparam int FREQ_W = 4;
  // divider counter long enough for a period of 2**15 cycles
  localparam int DIV_W  = 2**FREQ_W - 1;

  // register offsets, one word each
  localparam logic [ADDR_W-1:0] REG_CTRL = 32'h00;
  localparam logic [ADDR_W-1:0] REG_CHN  = 32'h04;
  localparam logic [ADDR_W-1:0] REG_MODE = 32'h08;
  localparam logic [ADDR_W-1:0] REG_FREQ = 32'h0C;
  localparam logic [ADDR_W-1:0] REG_PRE  = 32'h10;
  localparam logic [ADDR_W-1:0] REG_STAT = 32'h14;

  // status word layout
  localparam int STAT_DONE_BIT = 0;
  localparam int STAT_TA_LSB   = 16;
  localparam int STAT_TA_W     = 10;

  // sample window, word k holds sample k in its low byte
  localparam logic [ADDR_W-1:0] MEM_BASE = 32'h400;

  // trigger modes, codes above TRIG_EDGE act as TRIG_EDGE
  localparam logic [MODE_W-1:0] TRIG_RISE = 3'd0;
  localparam logic [MODE_W-1:0] TRIG_FALL = 3'd1;
  localparam logic [MODE_W-1:0] TRIG_HIGH = 3'd2;
  localparam logic [MODE_W-1:0] TRIG_LOW  = 3'd3;
  localparam logic [MODE_W-1:0] TRIG_EDGE = 3'd4;

endpackage

`default_nettype wire

//--- la_sample_mem.sv
/* single-port sample RAM; the capture write always has the port, the CPU read
   is granted in a free cycle and its data is valid one cycle after the grant */
`default_nettype none

module la_sample_mem import la_pkg::*; #(
  parameter  int MEM_DEPTH = 256,
  localparam int MEM_AW    = $clog2(MEM_DEPTH)
) (
  input  logic               sys_clk,
  input  logic               sys_rst_n,
  input  logic               i_wr_en,
  input  logic [MEM_AW-1:0]  i_wr_addr,
  input  logic [PROBE_W-1:0] i_wr_data,
  input  logic               i_rd_req,
  input  logic [MEM_AW-1:0]  i_rd_addr,
  output logic               o_rd_gnt,
  output logic [PROBE_W-1:0] o_rd_data
);

  logic [PROBE_W-1:0] mem [MEM_DEPTH];
  logic [MEM_AW-1:0]  port_addr;
  logic               gnt_q;

  // writer first; one grant per request, the requester drops req after it
  assign o_rd_gnt = i_rd_req & ~i_wr_en & ~gnt_q;

  // one shared address port
  assign port_addr = i_wr_en ? i_wr_addr : i_rd_addr;

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_n)
      gnt_q <= 1'b0;
    else
      gnt_q <= o_rd_gnt;
  end

  always_ff @(posedge sys_clk) begin
    if (i_wr_en)
      mem[port_addr] <= i_wr_data;
    else if (o_rd_gnt)
      o_rd_data <= mem[port_addr];
  end

endmodule

`default_nettype wire

//--- la_top.f
la_pkg.sv
la_icb_regs.sv
la_trigger.sv
la_capture.sv
la_sample_mem.sv
la_top.sv
la_asserts.sv
tb_la_top.sv

//--- la_top.sv
/* logic analyzer peripheral on a single clock; byte write masks are ignored
   and the bus error response is never raised */
`default_nettype none

module la_top import la_pkg::*; #(
  parameter  int MEM_DEPTH = 256,
  localparam int MEM_AW    = $clog2(MEM_DEPTH)
) (
  input  logic                sys_clk,
  input  logic                sys_rst_n,
  input  logic                i_icb_cmd_valid,
  output logic                o_icb_cmd_ready,
  input  logic [ADDR_W-1:0]   i_icb_cmd_addr,
  input  logic                i_icb_cmd_read,
  input  logic [DATA_W-1:0]   i_icb_cmd_wdata,
  input  logic [DATA_W/8-1:0] i_icb_cmd_wmask,
  output logic                o_icb_rsp_valid,
  input  logic                i_icb_rsp_ready,
  output logic                o_icb_rsp_err,
  output logic [DATA_W-1:0]   o_icb_rsp_rdata,
  input  logic [PROBE_W-1:0]  i_probe,
  output logic                o_done
);

  logic               arm;
  logic [CHN_W-1:0]   chn_sel;
  logic [MODE_W-1:0]  mode_sel;
  logic [FREQ_W-1:0]  freq_sel;
  logic [MEM_AW-1:0]  pre_num;
  logic               finished;
  logic [MEM_AW-1:0]  trig_addr;
  logic               smp_stb;
  logic [PROBE_W-1:0] smp_data;
  logic               hit_raw;
  logic               wr_en;
  logic [MEM_AW-1:0]  wr_addr;
  logic [PROBE_W-1:0] wr_data;
  logic               rd_req;
  logic [MEM_AW-1:0]  rd_addr;
  logic               rd_gnt;
  logic [PROBE_W-1:0] rd_data;

  la_icb_regs #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_regs (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .i_cmd_valid (i_icb_cmd_valid),
    .o_cmd_ready (o_icb_cmd_ready),
    .i_cmd_addr  (i_icb_cmd_addr),
    .i_cmd_read  (i_icb_cmd_read),
    .i_cmd_wdata (i_icb_cmd_wdata),
    .o_rsp_valid (o_icb_rsp_valid),
    .i_rsp_ready (i_icb_rsp_ready),
    .o_rsp_err   (o_icb_rsp_err),
    .o_rsp_rdata (o_icb_rsp_rdata),
    .i_finished  (finished),
    .i_trig_addr (trig_addr),
    .o_arm       (arm),
    .o_chn_sel   (chn_sel),
    .o_mode_sel  (mode_sel),
    .o_freq_sel  (freq_sel),
    .o_pre_num   (pre_num),
    .o_done      (o_done),
    .o_rd_req    (rd_req),
    .o_rd_addr   (rd_addr),
    .i_rd_gnt    (rd_gnt),
    .i_rd_data   (rd_data)
  );

  la_trigger u_trigger (
    .sys_clk    (sys_clk),
    .sys_rst_n  (sys_rst_n),
    .i_arm      (arm),
    .i_probe    (i_probe),
    .i_chn_sel  (chn_sel),
    .i_mode_sel (mode_sel),
    .i_freq_sel (freq_sel),
    .o_smp_stb  (smp_stb),
    .o_smp_data (smp_data),
    .o_hit_raw  (hit_raw)
  );

  la_capture #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_capture (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .i_arm       (arm),
    .i_pre_num   (pre_num),
    .i_smp_stb   (smp_stb),
    .i_smp_data  (smp_data),
    .i_hit_raw   (hit_raw),
    .o_wr_en     (wr_en),
    .o_wr_addr   (wr_addr),
    .o_wr_data   (wr_data),
    .o_finished  (finished),
    .o_trig_addr (trig_addr)
  );

  la_sample_mem #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_mem (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_rd_req  (rd_req),
    .i_rd_addr (rd_addr),
    .o_rd_gnt  (rd_gnt),
    .o_rd_data (rd_data)
  );

endmodule

`default_nettype wire

//--- la_trigger.sv
/* sample strobe every 2**freq_sel cycles, first one on the arming cycle;
   the first sample after arming never triggers */
`default_nettype none

module la_trigger import la_pkg::*; (
  input  logic               sys_clk,
  input  logic               sys_rst_n,
  input  logic               i_arm,
  input  logic [PROBE_W-1:0] i_probe,
  input  logic [CHN_W-1:0]   i_chn_sel,
  input  logic [MODE_W-1:0]  i_mode_sel,
  input  logic [FREQ_W-1:0]  i_freq_sel,
  output logic               o_smp_stb,
  output logic [PROBE_W-1:0] o_smp_data,
  output logic               o_hit_raw
);

  localparam logic [DIV_W-1:0] DIV_ONES = '1;

  logic               arm_q;
  logic               have_prev;
  logic [DIV_W-1:0]   div_cnt;
  logic [DIV_W-1:0]   div_last;
  logic [PROBE_W-1:0] prev_smp;
  logic               cur_bit;
  logic               prev_bit;
  logic               cond;

  // terminal count is 2**freq_sel - 1
  assign div_last  = DIV_ONES >> (DIV_W - 32'(i_freq_sel));
  assign o_smp_stb = i_arm & (~arm_q | (div_cnt == div_last));
  assign o_smp_data = i_probe;

  assign cur_bit  = i_probe[i_chn_sel];
  assign prev_bit = prev_smp[i_chn_sel];

  always_comb begin
    case (i_mode_sel)
      TRIG_RISE: cond = ~prev_bit & cur_bit;
      TRIG_FALL: cond = prev_bit & ~cur_bit;
      TRIG_HIGH: cond = cur_bit;
      TRIG_LOW:  cond = ~cur_bit;
      default:   cond = prev_bit ^ cur_bit;
    endcase
  end

  assign o_hit_raw = o_smp_stb & have_prev & cond;

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      arm_q     <= 1'b0;
      have_prev <= 1'b0;
      div_cnt   <= '0;
    end else begin
      arm_q <= i_arm;
      if (!i_arm) begin
        have_prev <= 1'b0;
        div_cnt   <= '0;
      end else if (o_smp_stb) begin
        have_prev <= 1'b1;
        div_cnt   <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // previous sample for the edge modes
  always_ff @(posedge sys_clk) begin
    if (o_smp_stb)
      prev_smp <= i_probe;
  end

endmodule

`default_nettype wire

//--- tb_la_top.sv
/* random test of la_top against a cycle model of the capture rules; captures keep
   freq_sel at 3 or below so that each window stays within a few thousand cycles */
`default_nettype none

module tb_la_top import la_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MEM_DEPTH   = 256;
  localparam int MEM_AW      = $clog2(MEM_DEPTH);
  localparam int MAX_FREQ    = 3;
  localparam int WDOG_CYCLES = 20 * MEM_DEPTH * (2**MAX_FREQ) * 2;

  logic                sys_clk;
  logic                sys_rst_n;
  logic                i_icb_cmd_valid;
  logic                o_icb_cmd_ready;
  logic [ADDR_W-1:0]   i_icb_cmd_addr;
  logic                i_icb_cmd_read;
  logic [DATA_W-1:0]   i_icb_cmd_wdata;
  logic [DATA_W/8-1:0] i_icb_cmd_wmask;
  logic                o_icb_rsp_valid;
  logic                i_icb_rsp_ready;
  logic                o_icb_rsp_err;
  logic [DATA_W-1:0]   o_icb_rsp_rdata;
  logic [PROBE_W-1:0]  i_probe;
  logic                o_done;

  // reference model state
  logic [PROBE_W-1:0] m_mem [MEM_DEPTH];
  logic [PROBE_W-1:0] m_prev;
  logic [CHN_W-1:0]   m_chn;
  logic [MODE_W-1:0]  m_mode;
  logic [FREQ_W-1:0]  m_freq;
  logic [MEM_AW-1:0]  m_pre;
  logic [MEM_AW-1:0]  m_waddr;
  logic [MEM_AW-1:0]  m_trig;
  logic [MEM_AW-1:0]  rd_idx;
  logic               m_arm;
  logic               m_done;
  logic               m_post;
  logic               rd_pend;
  int                 m_cyc;
  int                 m_idx;
  int                 m_left;
  logic [DATA_W-1:0]  exp_q [$];
  int                 errors;
  int                 seed;
  int                 probe_seed;

  la_top #(
    .MEM_DEPTH (MEM_DEPTH)
  ) dut0 (
    .sys_clk         (sys_clk),
    .sys_rst_n       (sys_rst_n),
    .i_icb_cmd_valid (i_icb_cmd_valid),
    .o_icb_cmd_ready (o_icb_cmd_ready),
    .i_icb_cmd_addr  (i_icb_cmd_addr),
    .i_icb_cmd_read  (i_icb_cmd_read),
    .i_icb_cmd_wdata (i_icb_cmd_wdata),
    .i_icb_cmd_wmask (i_icb_cmd_wmask),
    .o_icb_rsp_valid (o_icb_rsp_valid),
    .i_icb_rsp_ready (i_icb_rsp_ready),
    .o_icb_rsp_err   (o_icb_rsp_err),
    .o_icb_rsp_rdata (o_icb_rsp_rdata),
    .i_probe         (i_probe),
    .o_done          (o_done)
  );

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;
  end

  // probe bus changes every cycle
  always @(posedge sys_clk)
    i_probe <= PROBE_W'($random(probe_seed));

  function automatic logic trig_cond(logic [MODE_W-1:0] mode, logic p, logic c);
    case (mode)
      TRIG_RISE: return !p && c;
      TRIG_FALL: return p && !c;
      TRIG_HIGH: return c;
      TRIG_LOW:  return !c;
      default:   return p != c;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] reg_value(logic [ADDR_W-1:0] addr);
    case (addr)
      REG_CTRL: return DATA_W'(m_arm);
      REG_CHN:  return DATA_W'(m_chn);
      REG_MODE: return DATA_W'(m_mode);
      REG_FREQ: return DATA_W'(m_freq);
      REG_PRE:  return DATA_W'(m_pre);
      REG_STAT: return (DATA_W'(m_trig) << STAT_TA_LSB) | DATA_W'(m_done);
      default:  return '0;
    endcase
  endfunction

  function automatic logic in_window(logic [ADDR_W-1:0] addr);
    return (addr >= MEM_BASE) && (addr < MEM_BASE + 4 * MEM_DEPTH);
  endfunction

  task automatic compare(input string what, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
    case (addr)
      REG_CTRL: begin
        m_arm = wdata[0];
        if (wdata[0]) begin
          m_done  = 1'b0;
          m_cyc   = 0;
          m_idx   = 0;
          m_waddr = '0;
          m_post  = 1'b0;
        end
      end
      REG_CHN:  m_chn  = wdata[CHN_W-1:0];
      REG_MODE: m_mode = wdata[MODE_W-1:0];
      REG_FREQ: m_freq = wdata[FREQ_W-1:0];
      REG_PRE:  m_pre  = wdata[MEM_AW-1:0];
      default: ;
    endcase
  endtask

  // cycle model, all inputs and DUT outputs read as they were before the edge
  always @(posedge sys_clk) begin : ref_model
    logic               stb;
    logic               fin;
    logic [PROBE_W-1:0] cur;
    logic               hs;
    if (!sys_rst_n) begin
      m_arm   = 1'b0;
      m_done  = 1'b0;
      m_chn   = '0;
      m_mode  = '0;
      m_freq  = '0;
      m_pre   = '0;
      m_trig  = '0;
      m_post  = 1'b0;
      rd_pend = 1'b0;
    end else begin
      compare("done flag", DATA_W'(o_done), DATA_W'(m_done));
      stb = m_arm && ((m_cyc % (1 << m_freq)) == 0);
      fin = 1'b0;
      cur = i_probe;
      hs  = i_icb_cmd_valid && o_icb_cmd_ready;
      // window read is granted on the first cycle without a sample write
      if (rd_pend && !stb) begin
        exp_q.push_back(DATA_W'(m_mem[rd_idx]));
        rd_pend = 1'b0;
      end
      if (hs && i_icb_cmd_read) begin
        if (in_window(i_icb_cmd_addr)) begin
          rd_pend = 1'b1;
          rd_idx  = MEM_AW'((i_icb_cmd_addr - MEM_BASE) >> 2);
        end else begin
          exp_q.push_back(reg_value(i_icb_cmd_addr));
        end
      end
      if (stb) begin
        m_mem[m_waddr] = cur;
        if (!m_post && m_idx >= 1 && m_idx >= m_pre &&
            trig_cond(m_mode, m_prev[m_chn], cur[m_chn])) begin
          m_post = 1'b1;
          m_trig = m_waddr;
          m_left = MEM_DEPTH - m_pre - 1;
          fin    = (m_left == 0);
        end else if (m_post) begin
          m_left--;
          fin = (m_left == 0);
        end
        m_waddr++;
        m_prev = cur;
        m_idx++;
      end
      m_cyc++;
      if (hs && !i_icb_cmd_read)
        model_write(i_icb_cmd_addr, i_icb_cmd_wdata);
      // end of window wins over a write on the same edge
      if (fin) begin
        m_arm  = 1'b0;
        m_done = 1'b1;
      end
    end
  end

  task automatic send_cmd(input logic [ADDR_W-1:0] addr, input logic rd,
                          input logic [DATA_W-1:0] wdata);
    i_icb_cmd_valid <= 1'b1;
    i_icb_cmd_addr  <= addr;
    i_icb_cmd_read  <= rd;
    i_icb_cmd_wdata <= wdata;
    i_icb_cmd_wmask <= 4'($random(seed));
    @(posedge sys_clk);
    while (!o_icb_cmd_ready)
      @(posedge sys_clk);
    i_icb_cmd_valid <= 1'b0;
  endtask

  // random back-pressure, the held response must not change
  task automatic take_rsp(output logic [DATA_W-1:0] data);
    logic taken;
    logic seen;
    taken = 1'b0;
    seen  = 1'b0;
    while (!taken) begin
      i_icb_rsp_ready <= (($random(seed) & 3) != 0);
      @(posedge sys_clk);
      if (o_icb_rsp_valid) begin
        if (seen)
          compare("held response", o_icb_rsp_rdata, data);
        compare("response error", DATA_W'(o_icb_rsp_err), '0);
        data  = o_icb_rsp_rdata;
        seen  = 1'b1;
        taken = i_icb_rsp_ready;
      end
    end
    i_icb_rsp_ready <= 1'b0;
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
    logic [DATA_W-1:0] unused;
    send_cmd(addr, 1'b0, wdata);
    take_rsp(unused);
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] got;
    send_cmd(addr, 1'b1, '0);
    take_rsp(got);
    if (exp_q.size() == 0) begin
      errors++;
      $display("read at %h returned with no expected value from the model", addr);
    end else begin
      compare($sformatf("read at %h", addr), got, exp_q.pop_front());
    end
  endtask

  task automatic run_capture(input int mode, input int freq, input int pre, input int n_reads);
    int k;
    bus_write(REG_CHN, $random(seed));
    bus_write(REG_MODE, DATA_W'(mode));
    bus_write(REG_FREQ, DATA_W'(freq));
    bus_write(REG_PRE, DATA_W'(pre));
    bus_write(REG_CTRL, 32'h1);
    // re-arm has cleared done
    bus_read(REG_STAT);
    for (k = 0; k < n_reads; k++)
      bus_read(MEM_BASE + ADDR_W'(4 * ($random(seed) & (MEM_DEPTH - 1))));
    while (!o_done)
      @(posedge sys_clk);
    bus_read(REG_STAT);
    bus_read(REG_CTRL);
  endtask

  task automatic read_window();
    int k;
    for (k = 0; k < MEM_DEPTH; k++)
      bus_read(MEM_BASE + ADDR_W'(4 * k));
  endtask

  initial begin : watchdog
    repeat (WDOG_CYCLES) @(posedge sys_clk);
    $display("watchdog expired after %0d cycles before the tests completed", WDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  initial begin : stimulus
    logic [ADDR_W-1:0] addr;
    int                i;
    seed            = 72;
    probe_seed      = seed + 1;
    errors          = 0;
    sys_rst_n       = 1'b0;
    i_icb_cmd_valid = 1'b0;
    i_icb_cmd_addr  = '0;
    i_icb_cmd_read  = 1'b0;
    i_icb_cmd_wdata = '0;
    i_icb_cmd_wmask = '0;
    i_icb_rsp_ready = 1'b0;
    i_probe         = '0;
    repeat (10) @(posedge sys_clk);
    sys_rst_n <= 1'b1;
    @(posedge sys_clk);

    // register read-back, then unmapped holes below and above the window
    for (i = 0; i < 24; i++) begin
      addr = REG_CHN + ADDR_W'(4 * (i % 4));
      bus_write(addr, $random(seed));
      bus_read(addr);
    end
    bus_read(REG_STAT);
    for (i = 0; i < 8; i++) begin
      if (i % 2)
        addr = 32'h18 + ((ADDR_W'($random(seed)) & 32'hF7) << 2);
      else
        addr = MEM_BASE + 4 * MEM_DEPTH + (ADDR_W'($random(seed)) & 32'hFFC);
      bus_write(addr, $random(seed));
      bus_read(addr);
    end

    // every mode code, 5 to 7 act as edge
    for (i = 0; i < 8; i++)
      run_capture(i, $unsigned($random(seed)) % (MAX_FREQ + 1),
                  $random(seed) & (MEM_DEPTH - 1), 0);

    // full window read-back, first pass with pre_num 0
    for (i = 0; i < 4; i++) begin
      run_capture($random(seed) & 7, $unsigned($random(seed)) % (MAX_FREQ + 1),
                  (i == 0) ? 0 : ($random(seed) & (MEM_DEPTH - 1)), 0);
      read_window();
    end

    // window reads racing the capture writer
    for (i = 0; i < 2; i++)
      run_capture($random(seed) & 7, 1 + $unsigned($random(seed)) % MAX_FREQ,
                  $random(seed) & (MEM_DEPTH - 1), 16);

    $display("tb_la_top done: %0d check errors, %0d assertion failures",
             errors, dut0.u_asserts.fail_cnt);
    if (errors == 0 && dut0.u_asserts.fail_cnt == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire
